// File: verilog/ss_pkg.sv
package ss_pkg;

   // descriptor: word 0 buffer addr, word 1 count and last, word 2 next
   localparam int DESC_WORDS    = 3;     // 32-bit beats per descriptor
   localparam int DESC_LAST_BIT = 20;    // last flag in word 1, count in [15:0]

   // host register map, word offsets on adr[3:2]
   localparam logic [1:0] REG_CTRL = 2'd0;  // control word
   localparam logic [1:0] REG_SRC  = 2'd1;  // source chain head
   localparam logic [1:0] REG_DST  = 2'd2;  // destination chain head
   localparam logic [1:0] REG_STAT = 2'd3;  // status, read only

   localparam int CTRL_START_BIT  = 0;   // write 1 to kick a job
   localparam int CTRL_IRQ_EN_BIT = 1;   // interrupt enable

   localparam int STAT_BUSY_BIT  = 0;
   localparam int STAT_DONE_BIT  = 1;
   localparam int STAT_ERR_BIT   = 2;
   localparam int STAT_STATE_LSB = 4;    // failed walker state in [6:4]

   localparam int FIFO_DEPTH = 4;        // words between the walkers
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

   // walker states
   typedef enum logic [2:0] {
      SG_IDLE  = 3'd0,
      SG_DESC  = 3'd1,                   // descriptor fetch
      SG_WAIT  = 3'd2,                   // buffer wait on fifo
      SG_BUF   = 3'd3,                   // buffer word access
      SG_NEXT  = 3'd4,                   // next descriptor
      SG_END   = 3'd5,
      SG_PANIC = 3'd6                    // bus error seen
   } sg_state_e;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [31:0] adr;
      logic [31:0] dat;                  // write data
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic        err;
      logic [31:0] dat;                  // read data
   } wb_rsp_t;

endpackage

// File: verilog/ss_regs.sv
`timescale 1ns/1ps

module ss_regs import ss_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        wbs_cyc_i,
   input  logic        wbs_stb_i,
   input  logic        wbs_we_i,
   input  logic [31:0] wbs_adr_i,
   input  logic [31:0] wbs_dat_i,
   output logic [31:0] wbs_dat_o,
   output logic        wbs_ack_o,
   input  logic        rd_done_i,
   input  logic        wr_done_i,
   input  logic        rd_err_i,
   input  logic        wr_err_i,
   input  sg_state_e   rd_state_i,
   input  sg_state_e   wr_state_i,
   output logic        start_o,
   output logic [31:3] src_head_o,
   output logic [31:3] dst_head_o,
   output logic        irq_o
);

   logic        acc;                     // new strobe, not yet acked
   logic        wr_en;
   logic        ctrl_wr;
   logic        fin;                     // job finishing this cycle
   logic [31:0] ctrl_q;                  // start bit never stored
   logic        busy_q, done_q, err_q;
   sg_state_e   fail_q;                  // state of walker that panicked
   logic [31:0] stat;
   logic [31:0] rd_dat;

   assign acc     = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
   assign wr_en   = acc & wbs_we_i;
   assign ctrl_wr = wr_en && (wbs_adr_i[3:2] == REG_CTRL);
   assign start_o = ctrl_wr & wbs_dat_i[CTRL_START_BIT];  // one cycle, same edge as ack
   // both ended, or either one gave up
   assign fin     = busy_q & ((rd_done_i & wr_done_i) | rd_err_i | wr_err_i);

   always_comb begin
      stat = '0;
      stat[STAT_BUSY_BIT] = busy_q;
      stat[STAT_DONE_BIT] = done_q;
      stat[STAT_ERR_BIT]  = err_q;
      stat[STAT_STATE_LSB +: 3] = fail_q;
      case (wbs_adr_i[3:2])
         REG_CTRL: rd_dat = ctrl_q;
         REG_SRC:  rd_dat = {src_head_o, 3'b000};
         REG_DST:  rd_dat = {dst_head_o, 3'b000};
         default:  rd_dat = stat;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (acc)
         wbs_dat_o <= rd_dat;            // registered read data, valid with ack
      if (wr_en && wbs_adr_i[3:2] == REG_SRC)
         src_head_o <= wbs_dat_i[31:3];  // 8-byte aligned
      if (wr_en && wbs_adr_i[3:2] == REG_DST)
         dst_head_o <= wbs_dat_i[31:3];
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wbs_ack_o <= 1'b0;
         ctrl_q    <= '0;
         busy_q    <= 1'b0;
         done_q    <= 1'b0;
         err_q     <= 1'b0;
         fail_q    <= SG_IDLE;
         irq_o     <= 1'b0;
      end else begin
         wbs_ack_o <= acc;               // one ack per strobe
         if (ctrl_wr) begin
            ctrl_q <= wbs_dat_i;
            ctrl_q[CTRL_START_BIT] <= 1'b0;
            irq_o  <= 1'b0;              // any ctrl write drops irq
         end else if (fin && ctrl_q[CTRL_IRQ_EN_BIT]) begin
            irq_o  <= 1'b1;
         end
         if (start_o) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            err_q  <= 1'b0;
            fail_q <= SG_IDLE;
         end else if (fin) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
            err_q  <= rd_err_i | wr_err_i;
            if (rd_err_i)
               fail_q <= rd_state_i;
            else if (wr_err_i)
               fail_q <= wr_state_i;
         end
      end
   end

endmodule

// File: verilog/ss_sg.sv
`timescale 1ns/1ps

module ss_sg import ss_pkg::*; #(
   parameter bit WRITE_DIR = 1'b0        // 0 buffers to fifo, 1 fifo to buffers
) (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        start_i,
   input  logic [31:3] head_i,
   output wb_req_t     wbm_req_o,
   input  wb_rsp_t     wbm_rsp_i,
   input  logic        buf_valid_i,
   input  logic [31:0] buf_dat_i,
   input  logic        buf_ready_i,
   output logic        buf_pop_o,
   output logic        buf_push_o,
   output logic [31:0] buf_dat_o,
   output logic        done_o,
   output logic        err_o,
   output sg_state_e   state_o
);

   sg_state_e   state, state_n;
   sg_state_e   fail_q, fail_n;          // state where the bus error hit
   logic        cyc_q, cyc_n;
   logic [1:0]  beat_q, beat_n;          // descriptor word index
   logic [31:0] adr_q, adr_n;
   logic        we_q, we_n;
   logic [31:0] dat_q;
   logic        launch;                  // buffer beat raised this cycle

   logic [31:2] buf_adr;                 // current buffer word
   logic [15:0] len;                     // words left in this buffer
   logic        last;
   logic [31:3] next_ptr;

   logic        buf_ok;
   logic [31:0] desc_adr;
   logic        desc_ack, buf_ack;

   assign buf_ok   = WRITE_DIR ? buf_valid_i : buf_ready_i;  // fifo has word / room
   assign desc_adr = {next_ptr, 3'b000} + {28'd0, beat_q, 2'b00};
   assign desc_ack = (state == SG_DESC) && cyc_q && wbm_rsp_i.ack;
   assign buf_ack  = (state == SG_BUF) && cyc_q && wbm_rsp_i.ack;

   always_comb begin
      state_n = state;
      fail_n  = fail_q;
      cyc_n   = cyc_q;
      beat_n  = beat_q;
      adr_n   = adr_q;
      we_n    = we_q;
      launch  = 1'b0;
      case (state)
         SG_NEXT: begin
            if (last) begin
               state_n = SG_END;
            end else begin
               state_n = SG_DESC;
               beat_n  = '0;
            end
         end
         SG_DESC: begin
            if (!cyc_q) begin            // idle gap, start next beat
               cyc_n = 1'b1;
               adr_n = desc_adr;
               we_n  = 1'b0;
            end else if (wbm_rsp_i.err) begin
               cyc_n   = 1'b0;
               fail_n  = state;
               state_n = SG_PANIC;
            end else if (wbm_rsp_i.ack) begin
               cyc_n  = 1'b0;
               beat_n = beat_q + 2'd1;
               if (beat_q == DESC_WORDS - 1)
                  state_n = SG_WAIT;
            end
         end
         SG_WAIT: begin
            if (len == '0) begin
               state_n = SG_NEXT;        // empty segment
            end else if (buf_ok) begin
               cyc_n   = 1'b1;
               adr_n   = {buf_adr, 2'b00};
               we_n    = WRITE_DIR;
               launch  = 1'b1;
               state_n = SG_BUF;
            end
         end
         SG_BUF: begin
            if (wbm_rsp_i.err) begin
               cyc_n   = 1'b0;
               fail_n  = state;
               state_n = SG_PANIC;
            end else if (wbm_rsp_i.ack) begin
               cyc_n   = 1'b0;           // drop so the arbiter can switch
               state_n = (len == 16'd1) ? SG_NEXT : SG_WAIT;
            end
         end
         default: ;                      // idle, end and panic wait for start
      endcase
      if (start_i) begin                 // restart from anywhere
         state_n = SG_NEXT;
         cyc_n   = 1'b0;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state  <= SG_IDLE;
         fail_q <= SG_IDLE;
         cyc_q  <= 1'b0;
         beat_q <= '0;
      end else begin
         state  <= state_n;
         fail_q <= fail_n;
         cyc_q  <= cyc_n;
         beat_q <= beat_n;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      adr_q <= adr_n;
      we_q  <= we_n;
      if (launch)
         dat_q <= buf_dat_i;             // fifo head, held for the beat
      if (start_i) begin
         next_ptr <= head_i;
         last     <= 1'b0;               // so NEXT fetches the head
      end else if (desc_ack) begin
         case (beat_q)
            2'd0: buf_adr <= wbm_rsp_i.dat[31:2];
            2'd1: begin
               len  <= wbm_rsp_i.dat[15:0];
               last <= wbm_rsp_i.dat[DESC_LAST_BIT];
            end
            default: next_ptr <= wbm_rsp_i.dat[31:3];
         endcase
      end else if (buf_ack) begin
         buf_adr <= buf_adr + 30'd1;
         len     <= len - 16'd1;
      end
   end

   assign wbm_req_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat: dat_q};

   assign buf_push_o = !WRITE_DIR && buf_ack;  // read data into fifo
   assign buf_pop_o  = WRITE_DIR && buf_ack;   // word written, drop it
   assign buf_dat_o  = wbm_rsp_i.dat;

   assign done_o  = (state == SG_END);
   assign err_o   = (state == SG_PANIC);
   assign state_o = (state == SG_PANIC) ? fail_q : state;  // report where it failed

endmodule

// File: verilog/ss_fifo.sv
`timescale 1ns/1ps

module ss_fifo import ss_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        clr_i,            // start pulse, flush leftovers
   input  logic        push_i,
   input  logic [31:0] dat_i,
   output logic        full_o,
   input  logic        pop_i,
   output logic [31:0] dat_o,
   output logic        valid_o
);

   logic [31:0]        mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wp, rp;
   logic [FIFO_AW:0]   cnt;              // fill level 0..depth
   logic               do_push, do_pop;

   assign full_o  = (cnt == FIFO_DEPTH);
   assign valid_o = (cnt != '0);
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & valid_o;
   assign dat_o   = mem[rp];             // head word

   always_ff @(posedge wb_clk_i) begin
      if (do_push)
         mem[wp] <= dat_i;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wp  <= '0;
         rp  <= '0;
         cnt <= '0;
      end else if (clr_i) begin
         wp  <= '0;
         rp  <= '0;
         cnt <= '0;
      end else begin
         if (do_push)
            wp <= wp + 1'b1;             // wraps, depth is a power of two
         if (do_pop)
            rp <= rp + 1'b1;
         case ({do_push, do_pop})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: ;                   // both or neither
         endcase
      end
   end

endmodule

// File: verilog/ss_wb_arb.sv
`timescale 1ns/1ps

module ss_wb_arb import ss_pkg::*; (
   input  logic    wb_clk_i,
   input  logic    wb_rst_i,
   input  wb_req_t rd_req_i,
   input  wb_req_t wr_req_i,
   output wb_rsp_t rd_rsp_o,
   output wb_rsp_t wr_rsp_o,
   output wb_req_t wbm_req_o,
   input  wb_rsp_t wbm_rsp_i
);

   logic gnt_act;                        // someone held the bus last clock
   logic gnt_wr;                         // that someone was the write walker
   logic own_cyc;
   logic hold;
   logic sel_wr;

   assign own_cyc = gnt_wr ? wr_req_i.cyc : rd_req_i.cyc;
   assign hold    = gnt_act & own_cyc;   // owner keeps it until cyc drops
   assign sel_wr  = hold ? gnt_wr : wr_req_i.cyc;  // write walker wins a tie

   assign wbm_req_o = sel_wr ? wr_req_i : rd_req_i;

   always_comb begin
      rd_rsp_o = wbm_rsp_i;
      wr_rsp_o = wbm_rsp_i;
      if (sel_wr) begin                  // loser sees no ack or err
         rd_rsp_o.ack = 1'b0;
         rd_rsp_o.err = 1'b0;
      end else begin
         wr_rsp_o.ack = 1'b0;
         wr_rsp_o.err = 1'b0;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         gnt_act <= 1'b0;
         gnt_wr  <= 1'b0;
      end else begin
         gnt_act <= rd_req_i.cyc | wr_req_i.cyc;
         gnt_wr  <= sel_wr;
      end
   end

endmodule

// File: verilog/ss_top.sv
`timescale 1ns/1ps

module ss_top import ss_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        wbs_cyc_i,
   input  logic        wbs_stb_i,
   input  logic        wbs_we_i,
   input  logic [31:0] wbs_adr_i,
   input  logic [31:0] wbs_dat_i,
   output logic [31:0] wbs_dat_o,
   output logic        wbs_ack_o,
   output wb_req_t     wbm_req_o,
   input  wb_rsp_t     wbm_rsp_i,
   output logic        irq_o
);

   logic        start;
   logic [31:3] src_head, dst_head;
   logic        rd_done, wr_done, rd_err, wr_err;
   sg_state_e   rd_state, wr_state;
   wb_req_t     rd_req, wr_req;
   wb_rsp_t     rd_rsp, wr_rsp;
   logic        fifo_push, fifo_pop;
   logic        fifo_full, fifo_valid;
   logic [31:0] fifo_din, fifo_dout;

   ss_regs i_regs (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .wbs_cyc_i  (wbs_cyc_i),
      .wbs_stb_i  (wbs_stb_i),
      .wbs_we_i   (wbs_we_i),
      .wbs_adr_i  (wbs_adr_i),
      .wbs_dat_i  (wbs_dat_i),
      .wbs_dat_o  (wbs_dat_o),
      .wbs_ack_o  (wbs_ack_o),
      .rd_done_i  (rd_done),
      .wr_done_i  (wr_done),
      .rd_err_i   (rd_err),
      .wr_err_i   (wr_err),
      .rd_state_i (rd_state),
      .wr_state_i (wr_state),
      .start_o    (start),
      .src_head_o (src_head),
      .dst_head_o (dst_head),
      .irq_o      (irq_o)
   );

   // source chain, memory into fifo
   ss_sg #(.WRITE_DIR(1'b0)) i_sg_rd (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .start_i     (start),
      .head_i      (src_head),
      .wbm_req_o   (rd_req),
      .wbm_rsp_i   (rd_rsp),
      .buf_valid_i (1'b0),
      .buf_dat_i   (32'd0),
      .buf_ready_i (~fifo_full),
      .buf_pop_o   (),
      .buf_push_o  (fifo_push),
      .buf_dat_o   (fifo_din),
      .done_o      (rd_done),
      .err_o       (rd_err),
      .state_o     (rd_state)
   );

   // destination chain, fifo into memory
   ss_sg #(.WRITE_DIR(1'b1)) i_sg_wr (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .start_i     (start),
      .head_i      (dst_head),
      .wbm_req_o   (wr_req),
      .wbm_rsp_i   (wr_rsp),
      .buf_valid_i (fifo_valid),
      .buf_dat_i   (fifo_dout),
      .buf_ready_i (1'b0),
      .buf_pop_o   (fifo_pop),
      .buf_push_o  (),
      .buf_dat_o   (),
      .done_o      (wr_done),
      .err_o       (wr_err),
      .state_o     (wr_state)
   );

   ss_fifo i_fifo (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .clr_i    (start),
      .push_i   (fifo_push),
      .dat_i    (fifo_din),
      .full_o   (fifo_full),
      .pop_i    (fifo_pop),
      .dat_o    (fifo_dout),
      .valid_o  (fifo_valid)
   );

   ss_wb_arb i_arb (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .rd_req_i  (rd_req),
      .wr_req_i  (wr_req),
      .rd_rsp_o  (rd_rsp),
      .wr_rsp_o  (wr_rsp),
      .wbm_req_o (wbm_req_o),
      .wbm_rsp_i (wbm_rsp_i)
   );

endmodule

// File: test/tb_mem.sv
`timescale 1ns/1ps

module tb_mem import ss_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  wb_req_t     req_i,
   output wb_rsp_t     rsp_o,
   input  logic        ld_we_i,          // backdoor load from the testbench
   input  logic [31:0] ld_adr_i,
   input  logic [31:0] ld_dat_i
);

   logic [31:0] mem [1024];              // 4 KB, byte address [11:2]
   logic        busy;                    // beat seen, counting waits
   logic [1:0]  wait_cnt;
   integer      seed = 32'h50f6_b2f0;
   integer      rnd;

   always @(posedge wb_clk_i) begin
      rsp_o.ack <= 1'b0;                 // single cycle pulses
      rsp_o.err <= 1'b0;
      if (wb_rst_i) begin
         busy     <= 1'b0;
         wait_cnt <= 2'd0;
         for (int i = 0; i < 1024; i++)
            mem[i] <= 32'h5eed_0000 | (i << 2);  // fill tracks the address
      end else if (ld_we_i) begin
         mem[ld_adr_i[11:2]] <= ld_dat_i;
      end else if (req_i.cyc && req_i.stb && !rsp_o.ack && !rsp_o.err) begin
         if (!busy) begin
            rnd = $random(seed);
            busy     <= 1'b1;
            wait_cnt <= rnd[1:0];        // 0..3 wait states
         end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end else begin
            busy <= 1'b0;
            if (req_i.adr >= 32'h0000_0f00) begin
               rsp_o.err <= 1'b1;        // top of memory is the error region
            end else begin
               rsp_o.ack <= 1'b1;
               if (req_i.we)
                  mem[req_i.adr[11:2]] <= req_i.dat;
               else
                  rsp_o.dat <= mem[req_i.adr[11:2]];
            end
         end
      end
   end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ps

module tb_top import ss_pkg::*; ();

   logic        wb_clk = 1'b0;
   logic        wb_rst;
   logic        wbs_cyc, wbs_stb, wbs_we;
   logic [31:0] wbs_adr, wbs_dat_w;
   logic [31:0] wbs_dat_r;
   logic        wbs_ack;
   wb_req_t     wbm_req;
   wb_rsp_t     wbm_rsp;
   logic        irq;
   logic        ld_we;                   // memory preload
   logic [31:0] ld_adr, ld_dat;

   logic [31:0] td [512];                // records from the data file
   int          cycles = 0;
   int          limit = 32'h7fff_ffff;   // real limit set once the file is read
   int          errors = 0;              // mismatches in the running test
   int          n_ok = 0;
   int          n_bad = 0;

   always #5 wb_clk = ~wb_clk;

   ss_top i_dut (
      .wb_clk_i  (wb_clk),
      .wb_rst_i  (wb_rst),
      .wbs_cyc_i (wbs_cyc),
      .wbs_stb_i (wbs_stb),
      .wbs_we_i  (wbs_we),
      .wbs_adr_i (wbs_adr),
      .wbs_dat_i (wbs_dat_w),
      .wbs_dat_o (wbs_dat_r),
      .wbs_ack_o (wbs_ack),
      .wbm_req_o (wbm_req),
      .wbm_rsp_i (wbm_rsp),
      .irq_o     (irq)
   );

   tb_mem i_mem (
      .wb_clk_i (wb_clk),
      .wb_rst_i (wb_rst),
      .req_i    (wbm_req),
      .rsp_o    (wbm_rsp),
      .ld_we_i  (ld_we),
      .ld_adr_i (ld_adr),
      .ld_dat_i (ld_dat)
   );

   always @(posedge wb_clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("timeout after %0d cycles, a job never finished", cycles);
         $display("Test failed");
         $finish;
      end
   end

   task automatic next_cycle();
      @(posedge wb_clk);
      #1;                                // drive and sample clear of the edge
   endtask

   task automatic host_access(input logic we, input logic [1:0] ofs,
                              input logic [31:0] wdat, output logic [31:0] rdat);
      wbs_cyc   = 1'b1;
      wbs_stb   = 1'b1;
      wbs_we    = we;
      wbs_adr   = {28'd0, ofs, 2'b00};
      wbs_dat_w = wdat;
      do
         next_cycle();
      while (!wbs_ack);
      rdat    = wbs_dat_r;
      wbs_cyc = 1'b0;
      wbs_stb = 1'b0;
      wbs_we  = 1'b0;
   endtask

   task automatic load_word(input logic [31:0] adr, input logic [31:0] dat);
      ld_we  = 1'b1;
      ld_adr = adr;
      ld_dat = dat;
      next_cycle();
      ld_we  = 1'b0;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error at %0t: %s = %08h, expected %08h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input int num);
      if (errors == 0) begin
         n_ok++;
         $display("test %0d: ok", num);
      end else begin
         n_bad++;
         $display("test %0d: %0d mismatches", num, errors);
      end
      errors = 0;
   endtask

   initial begin
      int          p, n, r, k, total;
      logic [31:0] rdat, ctrl, exp_st, src_h, dst_h;
      $timeformat(-9, 0, " ns", 0);
      wb_rst    = 1'b1;
      wbs_cyc   = 1'b0;
      wbs_stb   = 1'b0;
      wbs_we    = 1'b0;
      wbs_adr   = '0;
      wbs_dat_w = '0;
      ld_we     = 1'b0;
      ld_adr    = '0;
      ld_dat    = '0;
      $readmemh("test/ss_testdata.txt", td);
      total = 0;                         // words plus descriptors over all records
      p = 1;
      for (r = 0; r < td[0]; r++) begin
         total += td[p];
         p += 5;
         p += 1 + 2 * td[p];             // skip preload pairs
         p += 1 + 2 * td[p];             // skip expected pairs
      end
      limit = 200 * total + 1000;
      repeat (16) @(posedge wb_clk);
      #1 wb_rst = 1'b0;

      // idle after reset
      host_access(1'b0, REG_STAT, 32'd0, rdat);
      check_value("status", rdat, 32'd0);
      for (k = 0; k < 20; k++) begin
         check_value("irq_o", {31'd0, irq}, 32'd0);
         next_cycle();
      end
      finish_test(1);

      p = 1;
      for (r = 0; r < td[0]; r++) begin
         ctrl   = td[p+1];
         src_h  = td[p+2];
         dst_h  = td[p+3];
         exp_st = td[p+4];
         n = td[p+5];
         p += 6;
         for (k = 0; k < n; k++) begin
            load_word(td[p], td[p+1]);
            p += 2;
         end
         host_access(1'b1, REG_SRC, src_h, rdat);
         host_access(1'b1, REG_DST, dst_h, rdat);
         host_access(1'b1, REG_CTRL, ctrl, rdat);
         if (ctrl[CTRL_IRQ_EN_BIT]) begin
            while (!irq)
               next_cycle();
            host_access(1'b0, REG_STAT, 32'd0, rdat);
         end else begin
            host_access(1'b0, REG_STAT, 32'd0, rdat);  // job still running here
            check_value("status busy", {31'd0, rdat[STAT_BUSY_BIT]}, 32'd1);
            while (rdat[STAT_BUSY_BIT])
               host_access(1'b0, REG_STAT, 32'd0, rdat);
         end
         check_value("status", rdat, exp_st);
         check_value("irq_o", {31'd0, irq}, {31'd0, ctrl[CTRL_IRQ_EN_BIT]});
         n = td[p];
         p += 1;
         for (k = 0; k < n; k++) begin
            check_value($sformatf("mem[%03h]", td[p][11:0]), i_mem.mem[td[p][11:2]],
                        td[p+1]);
            p += 2;
         end
         finish_test(r + 2);
      end

      $display("summary: %0d tests ok, %0d with mismatches", n_ok, n_bad);
      if (n_bad == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: test/ss_testdata.txt
// first word: record count; per record: load(words+descriptors) ctrl src_head dst_head status
// then n_preload and addr/data pairs to preload, then n_expect and addr/data pairs expected
00000006
// one 5-word segment into one 5-word segment, guard words around the destination
00000007 00000003 00000000 00000010 00000002
0000000d
00000000 00000100 00000004 00100005 00000008 00000000 00000010 00000200
00000014 00100005 00000018 00000000 00000100 a0000001 00000104 a0000002
00000108 a0000003 0000010c a0000004 00000110 a0000005 000001fc cafe01fc
00000214 cafe0214
00000007
00000200 a0000001 00000204 a0000002 00000208 a0000003 0000020c a0000004
00000210 a0000005 000001fc cafe01fc 00000214 cafe0214
// source segments 2, 3, 4 into destination segments 6, 3
0000000e 00000003 00000020 00000050 00000002
00000018
00000020 00000300 00000024 00000002 00000028 00000030 00000030 00000340
00000034 00000003 00000038 00000040 00000040 00000380 00000044 00100004
00000048 00000000 00000050 00000400 00000054 00000006 00000058 00000060
00000060 00000480 00000064 00100003 00000068 00000000 00000300 b0000001
00000304 b0000002 00000340 b0000003 00000344 b0000004 00000348 b0000005
00000380 b0000006 00000384 b0000007 00000388 b0000008 0000038c b0000009
00000009
00000400 b0000001 00000404 b0000002 00000408 b0000003 0000040c b0000004
00000410 b0000005 00000414 b0000006 00000480 b0000007 00000484 b0000008
00000488 b0000009
// 12 words through the 4-word fifo
0000000e 00000003 00000070 00000080 00000002
00000012
00000070 00000500 00000074 0010000c 00000078 00000000 00000080 00000600
00000084 0010000c 00000088 00000000 00000500 c0000001 00000504 c0000002
00000508 c0000003 0000050c c0000004 00000510 c0000005 00000514 c0000006
00000518 c0000007 0000051c c0000008 00000520 c0000009 00000524 c000000a
00000528 c000000b 0000052c c000000c
0000000c
00000600 c0000001 00000604 c0000002 00000608 c0000003 0000060c c0000004
00000610 c0000005 00000614 c0000006 00000618 c0000007 0000061c c0000008
00000620 c0000009 00000624 c000000a 00000628 c000000b 0000062c c000000c
// source next pointer into the error region, empty last destination segment
00000005 00000003 00000090 000000a0 00000016
00000009
00000090 00000700 00000094 00000002 00000098 00000f00 000000a0 00000780
000000a4 00100000 000000a8 00000000 00000700 d0000001 00000704 d0000002
00000780 cafe0780
00000001
00000780 cafe0780
// good job right after the error
00000005 00000003 000000b0 000000c0 00000002
00000009
000000b0 00000800 000000b4 00100003 000000b8 00000000 000000c0 00000880
000000c4 00100003 000000c8 00000000 00000800 e0000001 00000804 e0000002
00000808 e0000003
00000003
00000880 e0000001 00000884 e0000002 00000888 e0000003
// interrupt disabled, status polled
00000004 00000001 000000d0 000000e0 00000002
00000008
000000d0 00000900 000000d4 00100002 000000d8 00000000 000000e0 00000980
000000e4 00100002 000000e8 00000000 00000900 f0000001 00000904 f0000002
00000002
00000980 f0000001 00000984 f0000002

// File: tb.f
verilog/ss_pkg.sv
verilog/ss_regs.sv
verilog/ss_sg.sv
verilog/ss_fifo.sv
verilog/ss_wb_arb.sv
verilog/ss_top.sv
test/tb_mem.sv
test/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
